// File: source/raystore_pkg.sv
// ray store package: widths, ray vector struct, tag type, client count and client indices

package raystore_pkg;

	// ray id doubles as the memory address
	typedef logic [8:0] ray_id_t;

	// one coordinate, raw bits only
	typedef logic [15:0] coord_t;

	typedef struct packed {
		coord_t origin_x;
		coord_t origin_y;
		coord_t origin_z;
		coord_t dir_x;
		coord_t dir_y;
		coord_t dir_z;
	} ray_vec_t;

	// returned untouched with the read data
	typedef logic [7:0] rs_tag_t;

	localparam int num_clients = 4;

	// client index, also the round-robin pointer
	typedef logic [1:0] client_idx_t;

	localparam client_idx_t trav0 = 2'd0;
	localparam client_idx_t trav1 = 2'd1;
	localparam client_idx_t lcache = 2'd2;
	localparam client_idx_t list = 2'd3;

endpackage

// File: source/ram_if.sv
// ray memory port bundle interface with arbiter, memory and lane modports
`timescale 1ns/10ps

interface ram_if;

	// port a, shared by host writes and reads
	logic we;
	raystore_pkg::ray_id_t addr_a;
	raystore_pkg::ray_vec_t wdata;

	// port b, read only
	raystore_pkg::ray_id_t addr_b;

	// registered read data
	raystore_pkg::ray_vec_t q_a;
	raystore_pkg::ray_vec_t q_b;

	modport arb (output we, addr_a, wdata, addr_b);

	modport ram (input we, addr_a, wdata, addr_b, output q_a, q_b);

	modport lane (input q_a, q_b);

endinterface

// File: source/grant_if.sv
// lane to arbiter grant interface with lane and arbiter modports
`timescale 1ns/10ps

interface grant_if;

	// client request, as presented at the top level
	logic req_valid;
	raystore_pkg::ray_id_t req_id;

	// lane can take one more response
	logic room;

	// arbiter decision for this cycle
	logic grant;
	logic port_b;

	modport lane (output room, input grant, port_b);

	modport arb (input req_valid, req_id, room, output grant, port_b);

endinterface

// File: source/raystore_arb.sv
// round-robin two-grant arbiter with host write priority and memory address muxing
`timescale 1ns/10ps

module raystore_arb (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   wr_en,
	input  raystore_pkg::ray_id_t  wr_id,
	input  raystore_pkg::ray_vec_t wr_data,
	grant_if.arb                   lanes [raystore_pkg::num_clients],
	ram_if.arb                     ram
);

	logic [raystore_pkg::num_clients-1:0] req_valid_v;
	logic [raystore_pkg::num_clients-1:0] cand;
	logic [raystore_pkg::num_clients-1:0] grant_v;
	logic [raystore_pkg::num_clients-1:0] port_b_v;
	raystore_pkg::ray_id_t req_id_v [raystore_pkg::num_clients];

	raystore_pkg::client_idx_t ptr;
	raystore_pkg::client_idx_t idx;
	raystore_pkg::client_idx_t sel_a;
	raystore_pkg::client_idx_t sel_b;
	logic [1:0] n_grant;

	// unpack the lane bundles
	for (genvar g = 0; g < raystore_pkg::num_clients; g++) begin : g_port
		assign req_valid_v[g] = lanes[g].req_valid;
		assign req_id_v[g] = lanes[g].req_id;
		assign cand[g] = lanes[g].req_valid & lanes[g].room;
		assign lanes[g].grant = grant_v[g];
		assign lanes[g].port_b = port_b_v[g];
	end

	// pointer moves on any valid request, room or not
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ptr <= '0;
		end else if (!wr_en && (|req_valid_v)) begin
			ptr <= ptr + 1'b1;
		end
	end

	// scan from the pointer, first hit gets port a, second port b
	always_comb begin
		grant_v = '0;
		port_b_v = '0;
		sel_a = '0;
		sel_b = '0;
		n_grant = 2'd0;
		idx = ptr;
		for (int k = 0; k < raystore_pkg::num_clients; k++) begin
			idx = ptr + raystore_pkg::client_idx_t'(k);
			if (cand[idx] && n_grant < 2'd2) begin
				grant_v[idx] = 1'b1;
				if (n_grant == 2'd0) begin
					sel_a = idx;
				end else begin
					port_b_v[idx] = 1'b1;
					sel_b = idx;
				end
				n_grant = n_grant + 2'd1;
			end
		end
		// host write owns port a, all reads wait
		if (wr_en) begin
			grant_v = '0;
			port_b_v = '0;
		end
	end

	assign ram.we = wr_en;
	assign ram.wdata = wr_data;
	assign ram.addr_a = wr_en ? wr_id : req_id_v[sel_a];
	assign ram.addr_b = req_id_v[sel_b];

endmodule

// File: source/raystore_ram.sv
// dual-port ray memory, port a read/write and port b read only, registered outputs
`timescale 1ns/10ps

module raystore_ram (
	input  logic clk,
	input  logic arst_n,
	ram_if.ram   ram
);

	localparam int depth = 2 ** $bits(raystore_pkg::ray_id_t);

	raystore_pkg::ray_vec_t mem [depth];

	always_ff @(posedge clk) begin
		if (ram.we) begin
			mem[ram.addr_a] <= ram.wdata;
		end
	end

	// output registers clear like a block ram aclr
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ram.q_a <= '0;
			ram.q_b <= '0;
		end else if (!ram.we) begin
			ram.q_a <= mem[ram.addr_a];
			ram.q_b <= mem[ram.addr_b];
		end
	end

endmodule

// File: source/raystore_lane.sv
// per-client lane: in-flight read tracking, port select, response FIFO and room
`timescale 1ns/10ps

module raystore_lane #(
	parameter int fifo_depth = 2
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  raystore_pkg::rs_tag_t  req_tag,
	grant_if.lane                  arb,
	ram_if.lane                    ram,
	output logic                   rsp_valid,
	input  logic                   rsp_stall,
	output raystore_pkg::ray_vec_t rsp_data,
	output raystore_pkg::rs_tag_t  rsp_tag
);

	localparam int ptr_w = $clog2(fifo_depth);
	localparam int cnt_w = $clog2(fifo_depth + 1);

	logic in_flight;
	logic sel_b;
	raystore_pkg::rs_tag_t tag_q;
	raystore_pkg::ray_vec_t rd_data;

	raystore_pkg::ray_vec_t data_mem [fifo_depth];
	raystore_pkg::rs_tag_t tag_mem [fifo_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic push;
	logic pop;

	// one cycle of memory latency
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			in_flight <= 1'b0;
			sel_b <= 1'b0;
		end else begin
			in_flight <= arb.grant;
			sel_b <= arb.port_b;
		end
	end

	always_ff @(posedge clk) begin
		if (arb.grant) begin
			tag_q <= req_tag;
		end
	end

	assign rd_data = sel_b ? ram.q_b : ram.q_a;
	assign push = in_flight;
	assign pop = rsp_valid & ~rsp_stall;

	always_ff @(posedge clk) begin
		if (push) begin
			data_mem[wr_ptr] <= rd_data;
			tag_mem[wr_ptr] <= tag_q;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// slot freed by this cycle's pop counts, so a free-running lane keeps room
	assign arb.room = (int'(count) + int'(in_flight) - int'(pop)) < fifo_depth;

	assign rsp_valid = (count != '0);
	assign rsp_data = data_mem[rd_ptr];
	assign rsp_tag = tag_mem[rd_ptr];

endmodule

// File: source/raystore_top.sv
// ray store top level: client ports, four lanes, arbiter and ray memory
`timescale 1ns/10ps

module raystore_top #(
	parameter int fifo_depth = 2
) (
	input  logic                   clk,
	input  logic                   arst_n,

	// traversal unit 0
	input  logic                   trav0_req_valid,
	input  raystore_pkg::ray_id_t  trav0_req_id,
	input  raystore_pkg::rs_tag_t  trav0_req_tag,
	output logic                   trav0_req_stall,
	output logic                   trav0_rsp_valid,
	output raystore_pkg::ray_vec_t trav0_rsp_data,
	output raystore_pkg::rs_tag_t  trav0_rsp_tag,
	input  logic                   trav0_rsp_stall,

	// traversal unit 1
	input  logic                   trav1_req_valid,
	input  raystore_pkg::ray_id_t  trav1_req_id,
	input  raystore_pkg::rs_tag_t  trav1_req_tag,
	output logic                   trav1_req_stall,
	output logic                   trav1_rsp_valid,
	output raystore_pkg::ray_vec_t trav1_rsp_data,
	output raystore_pkg::rs_tag_t  trav1_rsp_tag,
	input  logic                   trav1_rsp_stall,

	// leaf cache
	input  logic                   lcache_req_valid,
	input  raystore_pkg::ray_id_t  lcache_req_id,
	input  raystore_pkg::rs_tag_t  lcache_req_tag,
	output logic                   lcache_req_stall,
	output logic                   lcache_rsp_valid,
	output raystore_pkg::ray_vec_t lcache_rsp_data,
	output raystore_pkg::rs_tag_t  lcache_rsp_tag,
	input  logic                   lcache_rsp_stall,

	// list unit
	input  logic                   list_req_valid,
	input  raystore_pkg::ray_id_t  list_req_id,
	input  raystore_pkg::rs_tag_t  list_req_tag,
	output logic                   list_req_stall,
	output logic                   list_rsp_valid,
	output raystore_pkg::ray_vec_t list_rsp_data,
	output raystore_pkg::rs_tag_t  list_rsp_tag,
	input  logic                   list_rsp_stall,

	// host loads rays
	input  logic                   wr_en,
	input  raystore_pkg::ray_id_t  wr_id,
	input  raystore_pkg::ray_vec_t wr_data
);

	localparam int n = raystore_pkg::num_clients;

	logic [n-1:0] req_valid_v;
	logic [n-1:0] req_stall_v;
	logic [n-1:0] rsp_valid_v;
	logic [n-1:0] rsp_stall_v;
	raystore_pkg::ray_id_t req_id_v [n];
	raystore_pkg::rs_tag_t req_tag_v [n];
	raystore_pkg::ray_vec_t rsp_data_v [n];
	raystore_pkg::rs_tag_t rsp_tag_v [n];

	ram_if ram_bus ();
	grant_if gnt [n] ();

	// gather client ports by index
	assign req_valid_v = {list_req_valid, lcache_req_valid, trav1_req_valid, trav0_req_valid};
	assign rsp_stall_v = {list_rsp_stall, lcache_rsp_stall, trav1_rsp_stall, trav0_rsp_stall};

	assign req_id_v[raystore_pkg::trav0] = trav0_req_id;
	assign req_id_v[raystore_pkg::trav1] = trav1_req_id;
	assign req_id_v[raystore_pkg::lcache] = lcache_req_id;
	assign req_id_v[raystore_pkg::list] = list_req_id;

	assign req_tag_v[raystore_pkg::trav0] = trav0_req_tag;
	assign req_tag_v[raystore_pkg::trav1] = trav1_req_tag;
	assign req_tag_v[raystore_pkg::lcache] = lcache_req_tag;
	assign req_tag_v[raystore_pkg::list] = list_req_tag;

	assign {list_req_stall, lcache_req_stall, trav1_req_stall, trav0_req_stall} = req_stall_v;
	assign {list_rsp_valid, lcache_rsp_valid, trav1_rsp_valid, trav0_rsp_valid} = rsp_valid_v;

	assign trav0_rsp_data = rsp_data_v[raystore_pkg::trav0];
	assign trav1_rsp_data = rsp_data_v[raystore_pkg::trav1];
	assign lcache_rsp_data = rsp_data_v[raystore_pkg::lcache];
	assign list_rsp_data = rsp_data_v[raystore_pkg::list];

	assign trav0_rsp_tag = rsp_tag_v[raystore_pkg::trav0];
	assign trav1_rsp_tag = rsp_tag_v[raystore_pkg::trav1];
	assign lcache_rsp_tag = rsp_tag_v[raystore_pkg::lcache];
	assign list_rsp_tag = rsp_tag_v[raystore_pkg::list];

	for (genvar g = 0; g < n; g++) begin : g_lane
		assign gnt[g].req_valid = req_valid_v[g];
		assign gnt[g].req_id = req_id_v[g];
		// stalled until granted
		assign req_stall_v[g] = gnt[g].req_valid & ~gnt[g].grant;

		raystore_lane #(
			.fifo_depth(fifo_depth)
		) i_lane (
			.clk,
			.arst_n,
			.req_tag(req_tag_v[g]),
			.arb(gnt[g]),
			.ram(ram_bus),
			.rsp_valid(rsp_valid_v[g]),
			.rsp_stall(rsp_stall_v[g]),
			.rsp_data(rsp_data_v[g]),
			.rsp_tag(rsp_tag_v[g])
		);
	end

	raystore_arb i_arb (
		.clk,
		.arst_n,
		.wr_en,
		.wr_id,
		.wr_data,
		.lanes(gnt),
		.ram(ram_bus)
	);

	raystore_ram i_ram (
		.clk,
		.arst_n,
		.ram(ram_bus)
	);

endmodule

// File: bench/raystore_model.svh
// reference model: shadow memory, expected response queues, arbiter pointer and grant scan

raystore_pkg::ray_vec_t shadow [512];
raystore_pkg::ray_vec_t exp_data [raystore_pkg::num_clients][$];
raystore_pkg::rs_tag_t exp_tag [raystore_pkg::num_clients][$];
raystore_pkg::client_idx_t model_ptr;
logic [3:0] model_inflight;

// every coordinate carries the whole ray id
function automatic raystore_pkg::ray_vec_t fill_pattern(raystore_pkg::ray_id_t id);
	raystore_pkg::ray_vec_t v;
	v.origin_x = {7'h11, id};
	v.origin_y = {7'h22, id};
	v.origin_z = {7'h33, id};
	v.dir_x = {7'h44, ~id};
	v.dir_y = {7'h55, id ^ 9'h1a5};
	v.dir_z = {7'h66, 9'(id + 9'd77)};
	return v;
endfunction

// two grants, scanning upward from the pointer, none during a host write
function automatic logic [3:0] scan_grants(logic [3:0] valid, logic [3:0] room, logic wr);
	logic [3:0] g;
	int n;
	raystore_pkg::client_idx_t idx;
	g = '0;
	n = 0;
	for (int k = 0; k < raystore_pkg::num_clients; k++) begin
		idx = model_ptr + raystore_pkg::client_idx_t'(k);
		if (valid[idx] && room[idx] && n < 2) begin
			g[idx] = 1'b1;
			n++;
		end
	end
	if (wr) begin
		g = '0;
	end
	return g;
endfunction

function automatic int pending();
	int n;
	n = 0;
	for (int c = 0; c < raystore_pkg::num_clients; c++) begin
		n += exp_data[c].size();
	end
	return n;
endfunction

// File: bench/raystore_tb.sv
// ray store testbench: clock, reset, random traffic, model based response and grant checks
`timescale 1ns/10ps

module raystore_tb;

	localparam int depth = 2;

	logic clk;
	logic arst_n;
	logic [3:0] req_valid;
	logic [3:0] rsp_stall;
	raystore_pkg::ray_id_t req_id [raystore_pkg::num_clients];
	raystore_pkg::rs_tag_t req_tag [raystore_pkg::num_clients];
	logic wr_en;
	raystore_pkg::ray_id_t wr_id;
	raystore_pkg::ray_vec_t wr_data;
	wire [3:0] req_stall;
	wire [3:0] rsp_valid;
	wire raystore_pkg::ray_vec_t rsp_data [raystore_pkg::num_clients];
	wire raystore_pkg::rs_tag_t rsp_tag [raystore_pkg::num_clients];
	logic [3:0] accepted;
	int valid_rate [raystore_pkg::num_clients];
	string test_name;

	`include "raystore_model.svh"

	raystore_top #(
		.fifo_depth(depth)
	) i_raystore_top (
		.clk,
		.arst_n,
		.trav0_req_valid(req_valid[0]),
		.trav0_req_id(req_id[0]),
		.trav0_req_tag(req_tag[0]),
		.trav0_req_stall(req_stall[0]),
		.trav0_rsp_valid(rsp_valid[0]),
		.trav0_rsp_data(rsp_data[0]),
		.trav0_rsp_tag(rsp_tag[0]),
		.trav0_rsp_stall(rsp_stall[0]),
		.trav1_req_valid(req_valid[1]),
		.trav1_req_id(req_id[1]),
		.trav1_req_tag(req_tag[1]),
		.trav1_req_stall(req_stall[1]),
		.trav1_rsp_valid(rsp_valid[1]),
		.trav1_rsp_data(rsp_data[1]),
		.trav1_rsp_tag(rsp_tag[1]),
		.trav1_rsp_stall(rsp_stall[1]),
		.lcache_req_valid(req_valid[2]),
		.lcache_req_id(req_id[2]),
		.lcache_req_tag(req_tag[2]),
		.lcache_req_stall(req_stall[2]),
		.lcache_rsp_valid(rsp_valid[2]),
		.lcache_rsp_data(rsp_data[2]),
		.lcache_rsp_tag(rsp_tag[2]),
		.lcache_rsp_stall(rsp_stall[2]),
		.list_req_valid(req_valid[3]),
		.list_req_id(req_id[3]),
		.list_req_tag(req_tag[3]),
		.list_req_stall(req_stall[3]),
		.list_rsp_valid(rsp_valid[3]),
		.list_rsp_data(rsp_data[3]),
		.list_rsp_tag(rsp_tag[3]),
		.list_rsp_stall(rsp_stall[3]),
		.wr_en,
		.wr_id,
		.wr_data
	);

	always #5 clk = ~clk;

	task automatic stop_run(string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_vec(string name, raystore_pkg::ray_vec_t expected,
			raystore_pkg::ray_vec_t actual);
		if (actual !== expected) begin
			stop_run($sformatf("FAIL %s %s expected %h actual %h", test_name, name,
				expected, actual));
		end
	endtask

	task automatic check_tag(string name, raystore_pkg::rs_tag_t expected,
			raystore_pkg::rs_tag_t actual);
		if (actual !== expected) begin
			stop_run($sformatf("FAIL %s %s expected %h actual %h", test_name, name,
				expected, actual));
		end
	endtask

	task automatic check_stall(string name, logic expected, logic actual);
		if (actual !== expected) begin
			stop_run($sformatf("FAIL %s %s expected %b actual %b", test_name, name,
				expected, actual));
		end
	endtask

	// one clock: check outputs against the model, then advance the model at the edge
	task automatic step_cycle();
		logic [3:0] room;
		logic [3:0] pop;
		logic [3:0] grant;
		int cnt;
		#1;
		for (int c = 0; c < raystore_pkg::num_clients; c++) begin
			// the newest entry is still in flight when accepted last cycle
			cnt = exp_data[c].size() - int'(model_inflight[c]);
			pop[c] = (cnt > 0) && !rsp_stall[c];
			room[c] = (exp_data[c].size() - int'(pop[c])) < depth;
			check_stall($sformatf("rsp_valid[%0d]", c), cnt > 0, rsp_valid[c]);
			if (cnt > 0) begin
				check_vec($sformatf("rsp_data[%0d]", c), exp_data[c][0], rsp_data[c]);
				check_tag($sformatf("rsp_tag[%0d]", c), exp_tag[c][0], rsp_tag[c]);
			end
		end
		grant = scan_grants(req_valid, room, wr_en);
		for (int c = 0; c < raystore_pkg::num_clients; c++) begin
			check_stall($sformatf("req_stall[%0d]", c), req_valid[c] & ~grant[c], req_stall[c]);
		end
		@(posedge clk);
		for (int c = 0; c < raystore_pkg::num_clients; c++) begin
			if (pop[c]) begin
				void'(exp_data[c].pop_front());
				void'(exp_tag[c].pop_front());
			end
			if (grant[c]) begin
				exp_data[c].push_back(shadow[req_id[c]]);
				exp_tag[c].push_back(req_tag[c]);
			end
		end
		if (wr_en) begin
			shadow[wr_id] = wr_data;
		end
		if (!wr_en && (|req_valid)) begin
			model_ptr = model_ptr + 1'b1;
		end
		model_inflight = grant;
		accepted = grant;
		@(negedge clk);
	endtask

	// a stalled request is held until accepted
	task automatic drive_random(int stall_pct, int wr_pct);
		for (int c = 0; c < raystore_pkg::num_clients; c++) begin
			if (!req_valid[c] || accepted[c]) begin
				req_valid[c] = ($urandom % 100) < valid_rate[c];
				req_id[c] = raystore_pkg::ray_id_t'($urandom);
				req_tag[c] = raystore_pkg::rs_tag_t'($urandom);
			end
			rsp_stall[c] = ($urandom % 100) < stall_pct;
		end
		wr_en = ($urandom % 100) < wr_pct;
		wr_id = raystore_pkg::ray_id_t'($urandom);
		wr_data = {$urandom, $urandom, $urandom};
	endtask

	task automatic run_phase(string name, int cycles, int stall_pct, int wr_pct);
		test_name = name;
		for (int c = 0; c < raystore_pkg::num_clients; c++) begin
			valid_rate[c] = 20 + ($urandom % 80);
		end
		repeat (cycles) begin
			drive_random(stall_pct, wr_pct);
			step_cycle();
		end
	endtask

	task automatic drain(int limit);
		int t;
		req_valid = '0;
		rsp_stall = '0;
		wr_en = 1'b0;
		t = 0;
		while (pending() != 0) begin
			if (t == limit) begin
				stop_run("timeout while draining outstanding responses");
			end
			step_cycle();
			t++;
		end
	endtask

	initial begin
		int t;
		void'($urandom(32'h17538039));
		clk = 1'b0;
		arst_n = 1'b0;
		req_valid = '0;
		rsp_stall = '0;
		wr_en = 1'b0;
		wr_id = '0;
		wr_data = '0;
		accepted = '0;
		model_ptr = '0;
		model_inflight = '0;
		for (int c = 0; c < raystore_pkg::num_clients; c++) begin
			req_id[c] = '0;
			req_tag[c] = '0;
		end
		repeat (2) @(negedge clk);
		arst_n = 1'b1;

		test_name = "reset";
		for (int c = 0; c < raystore_pkg::num_clients; c++) begin
			check_stall($sformatf("rsp_valid[%0d]", c), 1'b0, rsp_valid[c]);
		end

		test_name = "preload";
		wr_en = 1'b1;
		for (int i = 0; i < 512; i++) begin
			wr_id = raystore_pkg::ray_id_t'(i);
			wr_data = fill_pattern(wr_id);
			step_cycle();
		end

		test_name = "write_read";
		wr_id = 9'h0a5;
		wr_data = {$urandom, $urandom, $urandom};
		step_cycle();
		wr_en = 1'b0;
		for (int c = 0; c < raystore_pkg::num_clients; c++) begin
			req_valid[c] = 1'b1;
			req_id[c] = 9'h0a5;
			req_tag[c] = 8'h40 + 8'(c);
		end
		t = 0;
		while (req_valid != '0 || pending() != 0) begin
			if (t == 20) begin
				stop_run("timeout waiting for the write then read responses");
			end
			step_cycle();
			req_valid = req_valid & ~accepted;
			t++;
		end

		run_phase("grant_pattern", 400, 0, 0);
		run_phase("write_priority", 300, 0, 30);
		run_phase("back_pressure", 800, 50, 10);
		run_phase("stall_hold", 300, 95, 5);
		test_name = "final_drain";
		drain(100);
		// extra responses would show up as rsp_valid here
		repeat (4) step_cycle();

		$display("** PASS **");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+bench
source/raystore_pkg.sv
source/ram_if.sv
source/grant_if.sv
source/raystore_arb.sv
source/raystore_ram.sv
source/raystore_lane.sv
source/raystore_top.sv
bench/raystore_tb.sv

// File: Bender.yml
package:
  name: raystore

sources:
  - source/raystore_pkg.sv
  - source/ram_if.sv
  - source/grant_if.sv
  - source/raystore_arb.sv
  - source/raystore_ram.sv
  - source/raystore_lane.sv
  - source/raystore_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/raystore_tb.sv
